// ==== bench/muldiv_chk.sv ====
// hi/lo and stall assertions
`default_nettype none

module muldiv_chk (
   input wire        clk,
   input wire        rst,
   input wire [4:0]  alu_op,
   input wire        stall,
   input wire [31:0] hi,
   input wire [31:0] lo
);
   timeunit 1ns;
   timeprecision 1ps;

   logic is_mul;
   logic is_div;
   int   fail_cnt = 0;

   assign is_mul = alu_op inside {muldiv_pkg::OP_MULT, muldiv_pkg::OP_MULTU,
                                  muldiv_pkg::OP_MADD, muldiv_pkg::OP_MADDU,
                                  muldiv_pkg::OP_MSUB, muldiv_pkg::OP_MSUBU};
   assign is_div = alu_op inside {muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU};

   reset_stall: assert property (@(posedge clk) $rose(rst) |-> !stall)
      else begin
         fail_cnt++;
         $error("stall high in the first cycle after reset");
      end

   // multiply writes one cycle on, divide at the end of its done cycle
   hilo_write: assert property (@(posedge clk) disable iff (!rst)
      $changed({hi, lo}) |-> $past(is_mul) || ($past(is_div) && !$past(stall)))
      else begin
         fail_cnt++;
         $error("hi/lo changed without a finished multiply or divide");
      end

endmodule

bind muldiv_top muldiv_chk chk0 (
   .clk    (clk),
   .rst    (rst),
   .alu_op (alu_op),
   .stall  (stall),
   .hi     (hi),
   .lo     (lo)
);

`default_nettype wire

// ==== bench/muldiv_tb.sv ====
// multiply and divide unit testbench
`default_nettype none

module muldiv_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_RAND     = 400;
   localparam int N_DIR      = 10;
   localparam int CHAIN_OPS  = 150;                  // multiply-only stretch at the start
   localparam int DIV_CYCLES = 33;                   // stall high from op until done
   localparam int MAX_CYCLES = (N_RAND + N_DIR) * 36 + 100;

   logic        clk;
   logic        rst;
   logic [4:0]  alu_op;
   logic [31:0] src_a;
   logic [31:0] src_b;
   logic        flush;
   logic        stall;
   logic [31:0] hi;
   logic [31:0] lo;

   logic [63:0] m_hilo;                              // model of hi:lo
   int          errors;
   int          checks;
   int          cycles;

   muldiv_top dut0 (
      .clk    (clk),
      .rst    (rst),
      .alu_op (alu_op),
      .src_a  (src_a),
      .src_b  (src_b),
      .flush  (flush),
      .stall  (stall),
      .hi     (hi),
      .lo     (lo)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("run did not finish within %0d cycles", MAX_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // 64 bit product, wraps like the hardware register
   function automatic logic [63:0] product(input logic [4:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
      logic signed [63:0] sa;
      logic signed [63:0] sb;
      if (op == muldiv_pkg::OP_MULT || op == muldiv_pkg::OP_MADD ||
          op == muldiv_pkg::OP_MSUB) begin
         sa = {{32{a[31]}}, a};
         sb = {{32{b[31]}}, b};
         return sa * sb;
      end
      return {32'd0, a} * {32'd0, b};
   endfunction

   // returns {rem, quo}
   function automatic logic [63:0] quo_rem(input logic [4:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
      logic        an;
      logic        bn;
      logic [31:0] am;
      logic [31:0] bm;
      logic [31:0] q;
      logic [31:0] r;
      an = (op == muldiv_pkg::OP_DIV) & a[31];
      bn = (op == muldiv_pkg::OP_DIV) & b[31];
      am = an ? 32'd0 - a : a;
      bm = bn ? 32'd0 - b : b;
      if (bm == 32'd0) begin
         q = '1;                                     // divide by zero
         r = am;
      end else begin
         q = am / bm;
         r = am % bm;
      end
      if (an ^ bn) q = 32'd0 - q;
      if (an) r = 32'd0 - r;
      return {r, q};
   endfunction

   task automatic apply_model(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b);
      case (op)
         muldiv_pkg::OP_MULT, muldiv_pkg::OP_MULTU: m_hilo = product(op, a, b);
         muldiv_pkg::OP_MADD, muldiv_pkg::OP_MADDU: m_hilo = m_hilo + product(op, a, b);
         muldiv_pkg::OP_MSUB, muldiv_pkg::OP_MSUBU: m_hilo = m_hilo - product(op, a, b);
         muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU:   m_hilo = quo_rem(op, a, b);
         default: ;                                  // no-op codes
      endcase
   endtask

   // one op, held while stalled, flush_cyc < 0 means no flush
   task automatic issue_op(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
                           input int flush_cyc);
      int n;
      bit flushed;
      bit is_div;
      n       = 0;
      flushed = 1'b0;
      is_div  = (op == muldiv_pkg::OP_DIV) || (op == muldiv_pkg::OP_DIVU);
      @(posedge clk);
      alu_op <= op;
      src_a  <= a;
      src_b  <= b;
      flush  <= (flush_cyc == 0);
      forever begin
         @(negedge clk);
         if (n == flush_cyc) begin
            flushed = 1'b1;
            break;
         end
         if (!stall) break;
         n++;
         @(posedge clk);
         flush <= (n == flush_cyc);
      end
      @(posedge clk);
      alu_op <= muldiv_pkg::OP_NOP;
      flush  <= 1'b0;
      if (!flushed) apply_model(op, a, b);
      if (!flushed && is_div) begin
         assert (n == DIV_CYCLES) else begin
            errors++;
            $display("ERR %0t stall cycles got %0d exp %0d", $time, n, DIV_CYCLES);
         end
      end
      @(negedge clk);
      checks++;
      assert (stall === 1'b0) else begin
         errors++;
         $display("ERR %0t stall got %b exp 0 (op %0d)", $time, stall, op);
      end
      assert (hi === m_hilo[63:32]) else begin
         errors++;
         $display("ERR %0t hi got %h exp %h (op %0d a %h b %h)", $time, hi, m_hilo[63:32],
                  op, a, b);
      end
      assert (lo === m_hilo[31:0]) else begin
         errors++;
         $display("ERR %0t lo got %h exp %h (op %0d a %h b %h)", $time, lo, m_hilo[31:0],
                  op, a, b);
      end
   endtask

   // operands biased towards the corner values
   function automatic logic [31:0] pick_word();
      case ($urandom_range(0, 7))
         0: return 32'h8000_0000;
         1: return 32'hffff_ffff;
         2: return 32'd0;
         3: return 32'($signed($urandom_range(0, 32)) - 16);
         default: return $urandom;
      endcase
   endfunction

   function automatic logic [4:0] pick_op(input bit mul_only);
      if (mul_only) return 5'($urandom_range(1, 6));
      case ($urandom_range(0, 11))
         0: return muldiv_pkg::OP_NOP;
         1: return 5'd20;                            // unknown code, acts as nop
         2, 3, 4: return muldiv_pkg::OP_DIV;
         5, 6: return muldiv_pkg::OP_DIVU;
         default: return 5'($urandom_range(1, 6));
      endcase
   endfunction

   initial begin
      logic [4:0] op;
      int         fc;
      void'($urandom(81));
      clk    = 1'b0;
      rst    = 1'b0;
      alu_op = muldiv_pkg::OP_NOP;
      src_a  = '0;
      src_b  = '0;
      flush  = 1'b0;
      m_hilo = '0;
      errors = 0;
      checks = 0;
      cycles = 0;
      repeat (2) @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
      checks++;
      assert (hi === 32'd0 && lo === 32'd0 && stall === 1'b0) else begin
         errors++;
         $display("ERR %0t hi %h lo %h stall %b after reset, exp all zero", $time, hi, lo,
                  stall);
      end

      // corner cases first
      issue_op(muldiv_pkg::OP_MULT,  32'h8000_0000, 32'h8000_0000, -1);
      issue_op(muldiv_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, -1);
      issue_op(muldiv_pkg::OP_MADD,  32'hffff_ffff, 32'h8000_0000, -1);
      issue_op(muldiv_pkg::OP_MSUBU, 32'hffff_ffff, 32'h0000_0002, -1);
      issue_op(muldiv_pkg::OP_DIV,   32'h8000_0000, 32'hffff_ffff, -1);
      issue_op(muldiv_pkg::OP_DIV,   32'hffff_fff9, 32'h0000_0002, -1);
      issue_op(muldiv_pkg::OP_DIV,   32'h0000_0007, 32'hffff_fffe, -1);
      issue_op(muldiv_pkg::OP_DIV,   32'hffff_fff9, 32'h0000_0000, -1);
      issue_op(muldiv_pkg::OP_DIVU,  32'h1234_5678, 32'h0000_0000, -1);
      issue_op(muldiv_pkg::OP_MULT,  32'h0000_0003, 32'h0000_0005, 0);

      for (int i = 0; i < N_RAND; i++) begin
         op = pick_op(i < CHAIN_OPS);
         fc = -1;
         if ($urandom_range(0, 7) == 0) begin
            fc = (op == muldiv_pkg::OP_DIV || op == muldiv_pkg::OP_DIVU) ?
                 $urandom_range(0, DIV_CYCLES) : 0;
         end
         issue_op(op, pick_word(), pick_word(), fc);
      end

      $display("checks %0d errors %0d assertion failures %0d", checks, errors,
               dut0.chk0.fail_cnt);
      if (errors == 0 && dut0.chk0.fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/div_unit.sv ====
// iterative restoring divider
`default_nettype none

module div_unit (
   input  wire                    clk,
   input  wire                    rst,
   exe_op_if.unit                 opi,
   output logic                   stall,
   output logic                   div_done,
   output muldiv_pkg::hilo_word_u div_res
);

   localparam logic [muldiv_pkg::DIV_CNT_W-1:0] LAST_STEP =
      muldiv_pkg::DIV_CNT_W'(muldiv_pkg::DIV_STEPS - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUSY,
      ST_DONE
   } state_e;

   state_e                           state;
   logic [muldiv_pkg::DIV_CNT_W-1:0] step_cnt;
   logic [muldiv_pkg::WORD_W-1:0]    quo;      // dividend shifts out, quotient shifts in
   logic [muldiv_pkg::WORD_W-1:0]    rem;
   logic [muldiv_pkg::WORD_W-1:0]    dvs;
   logic                             neg_q;
   logic                             neg_r;
   logic                             is_div;
   logic                             is_signed;
   logic                             a_neg;
   logic                             b_neg;
   logic [muldiv_pkg::WORD_W-1:0]    a_mag;
   logic [muldiv_pkg::WORD_W-1:0]    b_mag;
   logic [muldiv_pkg::WORD_W:0]      trial;
   logic                             fits;

   assign is_div    = (opi.op == muldiv_pkg::OP_DIV) || (opi.op == muldiv_pkg::OP_DIVU);
   assign is_signed = opi.op == muldiv_pkg::OP_DIV;

   // magnitudes, 0x80000000 stays as is and reads fine unsigned
   assign a_neg = is_signed & opi.a[muldiv_pkg::WORD_W-1];
   assign b_neg = is_signed & opi.b[muldiv_pkg::WORD_W-1];
   assign a_mag = a_neg ? -opi.a : opi.a;
   assign b_mag = b_neg ? -opi.b : opi.b;

   // one restoring step
   assign trial = {rem, quo[muldiv_pkg::WORD_W-1]};
   assign fits  = trial >= {1'b0, dvs};     // always true for a zero divisor

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state    <= ST_IDLE;
         step_cnt <= '0;
      end else if (opi.flush) begin
         state <= ST_IDLE;                  // cancel whatever is in flight
      end else begin
         case (state)
            ST_IDLE: begin
               if (is_div) begin
                  state    <= ST_BUSY;
                  step_cnt <= '0;
               end
            end
            ST_BUSY: begin
               step_cnt <= step_cnt + 1'b1;
               if (step_cnt == LAST_STEP) begin
                  state <= ST_DONE;
               end
            end
            default: begin
               state <= ST_IDLE;            // done lasts one cycle
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && is_div) begin
         quo   <= a_mag;
         rem   <= '0;
         dvs   <= b_mag;
         neg_q <= a_neg ^ b_neg;
         neg_r <= a_neg;                    // remainder follows the dividend
      end else if (state == ST_BUSY) begin
         quo <= {quo[muldiv_pkg::WORD_W-2:0], fits};
         rem <= fits ? trial[muldiv_pkg::WORD_W-1:0] - dvs : trial[muldiv_pkg::WORD_W-1:0];
      end
   end

   // sign fix-up on the way out
   always_comb begin
      div_res.qr.quo = neg_q ? -quo : quo;
      div_res.qr.rem = neg_r ? -rem : rem;
   end

   assign div_done = (state == ST_DONE) & ~opi.flush;
   assign stall    = is_div & (state != ST_DONE);

endmodule

`default_nettype wire

// ==== hdl/exe_op_if.sv ====
// execute stage operation bus
`default_nettype none

interface exe_op_if;

   logic [muldiv_pkg::OP_W-1:0]   op;
   logic [muldiv_pkg::WORD_W-1:0] a;      // rs
   logic [muldiv_pkg::WORD_W-1:0] b;      // rt
   logic                          flush;  // exception in a later stage

   // pipeline side
   modport src (
      output op,
      output a,
      output b,
      output flush
   );

   // mul and div units only listen
   modport unit (
      input op,
      input a,
      input b,
      input flush
   );

endinterface

`default_nettype wire

// ==== hdl/hilo_combine.sv ====
// hi and lo registers
`default_nettype none

module hilo_combine (
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               mul_valid,
   input  wire muldiv_pkg::acc_mode_e        mul_mode,
   input  wire muldiv_pkg::hilo_word_u       mul_res,
   input  wire                               div_done,
   input  wire muldiv_pkg::hilo_word_u       div_res,
   output logic [muldiv_pkg::WORD_W-1:0]     hi,
   output logic [muldiv_pkg::WORD_W-1:0]     lo
);

   logic [2*muldiv_pkg::WORD_W-1:0] hilo_cur;
   logic [2*muldiv_pkg::WORD_W-1:0] mul_next;

   assign hilo_cur = {hi, lo};

   // 64 bit accumulate, wraps silently
   always_comb begin
      case (mul_mode)
         muldiv_pkg::ACC_ADD: begin
            mul_next = hilo_cur + mul_res.prod;
         end
         muldiv_pkg::ACC_SUB: begin
            mul_next = hilo_cur - mul_res.prod;
         end
         default: begin
            mul_next = mul_res.prod;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         hi <= '0;
         lo <= '0;
      end else if (div_done) begin
         hi <= div_res.qr.rem;
         lo <= div_res.qr.quo;
      end else if (mul_valid) begin
         hi <= mul_next[2*muldiv_pkg::WORD_W-1:muldiv_pkg::WORD_W];
         lo <= mul_next[muldiv_pkg::WORD_W-1:0];
      end
   end

endmodule

`default_nettype wire

// ==== hdl/mul_unit.sv ====
// single cycle multiplier
`default_nettype none

module mul_unit (
   exe_op_if.unit                 opi,
   output logic                   mul_valid,
   output muldiv_pkg::acc_mode_e  mul_mode,
   output muldiv_pkg::hilo_word_u mul_res
);

   logic                                   is_mul;
   logic                                   is_signed;
   logic [muldiv_pkg::WORD_W:0]            a_ext;
   logic [muldiv_pkg::WORD_W:0]            b_ext;
   logic signed [2*muldiv_pkg::WORD_W+1:0] prod_full;

   // op decode into signedness and accumulate mode
   always_comb begin
      is_mul    = 1'b1;
      is_signed = 1'b0;
      mul_mode  = muldiv_pkg::ACC_SET;
      case (opi.op)
         muldiv_pkg::OP_MULT: begin
            is_signed = 1'b1;
         end
         muldiv_pkg::OP_MULTU: begin
            is_signed = 1'b0;
         end
         muldiv_pkg::OP_MADD: begin
            is_signed = 1'b1;
            mul_mode  = muldiv_pkg::ACC_ADD;
         end
         muldiv_pkg::OP_MADDU: begin
            mul_mode = muldiv_pkg::ACC_ADD;
         end
         muldiv_pkg::OP_MSUB: begin
            is_signed = 1'b1;
            mul_mode  = muldiv_pkg::ACC_SUB;
         end
         muldiv_pkg::OP_MSUBU: begin
            mul_mode = muldiv_pkg::ACC_SUB;
         end
         default: begin
            is_mul = 1'b0;                       // div or nop
         end
      endcase
   end

   // 33 bit operands, so one signed multiplier covers both flavours
   assign a_ext = {is_signed & opi.a[muldiv_pkg::WORD_W-1], opi.a};
   assign b_ext = {is_signed & opi.b[muldiv_pkg::WORD_W-1], opi.b};

   assign prod_full = $signed(a_ext) * $signed(b_ext);

   always_comb begin
      mul_res.prod = prod_full[2*muldiv_pkg::WORD_W-1:0];  // top two bits are sign copies
   end

   assign mul_valid = is_mul & ~opi.flush;

endmodule

`default_nettype wire

// ==== hdl/muldiv_pkg.sv ====
// multiply and divide unit definitions
`default_nettype none

package muldiv_pkg;

   localparam int OP_W      = 5;
   localparam int WORD_W    = 32;
   localparam int DIV_STEPS = 32;                  // one quotient bit per step
   localparam int DIV_CNT_W = $clog2(DIV_STEPS);

   // alu op codes handled here, anything else is a nop
   localparam logic [OP_W-1:0] OP_NOP   = 5'd0;
   localparam logic [OP_W-1:0] OP_MULT  = 5'd1;
   localparam logic [OP_W-1:0] OP_MULTU = 5'd2;
   localparam logic [OP_W-1:0] OP_MADD  = 5'd3;
   localparam logic [OP_W-1:0] OP_MADDU = 5'd4;
   localparam logic [OP_W-1:0] OP_MSUB  = 5'd5;
   localparam logic [OP_W-1:0] OP_MSUBU = 5'd6;
   localparam logic [OP_W-1:0] OP_DIV   = 5'd7;
   localparam logic [OP_W-1:0] OP_DIVU  = 5'd8;

   // what the multiplier does with hi:lo
   typedef enum logic [1:0] {
      ACC_SET = 2'b00,                             // overwrite with product
      ACC_ADD = 2'b01,                             // madd / maddu
      ACC_SUB = 2'b10                              // msub / msubu
   } acc_mode_e;

   typedef struct packed {
      logic [WORD_W-1:0] rem;                      // to hi
      logic [WORD_W-1:0] quo;                      // to lo
   } div_qr_t;

   // same 64 bits, seen as product or as rem:quo
   typedef union packed {
      logic [2*WORD_W-1:0] prod;
      div_qr_t             qr;
   } hilo_word_u;

endpackage

`default_nettype wire

// ==== hdl/muldiv_top.sv ====
// multiply and divide unit top
`default_nettype none

module muldiv_top (
   input  wire                           clk,
   input  wire                           rst,
   input  wire [muldiv_pkg::OP_W-1:0]    alu_op,
   input  wire [muldiv_pkg::WORD_W-1:0]  src_a,
   input  wire [muldiv_pkg::WORD_W-1:0]  src_b,
   input  wire                           flush,
   output logic                          stall,
   output logic [muldiv_pkg::WORD_W-1:0] hi,
   output logic [muldiv_pkg::WORD_W-1:0] lo
);

   logic                   mul_valid;
   muldiv_pkg::acc_mode_e  mul_mode;
   muldiv_pkg::hilo_word_u mul_res;
   logic                   div_done;
   muldiv_pkg::hilo_word_u div_res;

   exe_op_if opi ();

   // pipeline side of the bus
   assign opi.op    = alu_op;
   assign opi.a     = src_a;
   assign opi.b     = src_b;
   assign opi.flush = flush;

   mul_unit mul0 (
      .opi       (opi.unit),
      .mul_valid (mul_valid),
      .mul_mode  (mul_mode),
      .mul_res   (mul_res)
   );

   div_unit div0 (
      .clk      (clk),
      .rst      (rst),
      .opi      (opi.unit),
      .stall    (stall),
      .div_done (div_done),
      .div_res  (div_res)
   );

   hilo_combine hilo0 (
      .clk       (clk),
      .rst       (rst),
      .mul_valid (mul_valid),
      .mul_mode  (mul_mode),
      .mul_res   (mul_res),
      .div_done  (div_done),
      .div_res   (div_res),
      .hi        (hi),
      .lo        (lo)
   );

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/muldiv_pkg.sv
hdl/exe_op_if.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/hilo_combine.sv
hdl/muldiv_top.sv
bench/muldiv_chk.sv
bench/muldiv_tb.sv
